// File: sim.f
+incdir+dv
logic/z8Pkg.sv
logic/z8Ifs.sv
logic/aluUnit.sv
logic/regFile.sv
logic/fetchUnit.sv
logic/execUnit.sv
logic/z8Core.sv
dv/z8Tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module z8Tb -Mdir obj_dir -f sim.f
out=$(./obj_dir/Vz8Tb)
echo "$out"
echo "$out" | grep -qx "all tests passed"

// File: dv/z8TbTasks.svh
function automatic logic condHolds(input logic [3:0] cc, input logic [7:0] f);
    logic c;
    logic z;
    logic s;
    logic v;
    logic base;
    c = f[z8Pkg::flagC];
    z = f[z8Pkg::flagZ];
    s = f[z8Pkg::flagS];
    v = f[z8Pkg::flagV];
    case (cc[2:0])
        3'd0: base = 1'b0;
        3'd1: base = s ^ v;
        3'd2: base = (s ^ v) | z;
        3'd3: base = c | z;
        3'd4: base = v;
        3'd5: base = s;
        3'd6: base = z;
        default: base = c;
    endcase
    return base ^ cc[3];
endfunction

task automatic twoOpResult(input logic [3:0] op, input logic [7:0] a, input logic [7:0] b,
                           output logic [7:0] res);
    int cin;
    int lowN;
    int full;
    logic isSub;
    cin = (op == 4'h1 || op == 4'h3) ? int'(flagsM[z8Pkg::flagC]) : 0;
    isSub = op inside {4'h2, 4'h3, 4'hA};
    if (op <= 4'h3 || op == 4'hA) begin
        if (isSub) begin
            lowN = int'(a[3:0]) - int'(b[3:0]) - cin;
            full = int'(a) - int'(b) - cin;
        end else begin
            lowN = int'(a[3:0]) + int'(b[3:0]) + cin;
            full = int'(a) + int'(b) + cin;
        end
        res = full[7:0];
        flagsM[z8Pkg::flagH] = lowN < 0 || lowN > 15;
        flagsM[z8Pkg::flagC] = full < 0 || full > 255;
        flagsM[z8Pkg::flagD] = isSub;
        flagsM[z8Pkg::flagV] = (a[7] == b[7]) && (res[7] != a[7]);
    end else begin
        case (op)
            4'h4: res = a | b;
            4'h6: res = ~a & b;
            4'hB: res = a ^ b;
            default: res = a & b;
        endcase
        flagsM[z8Pkg::flagV] = 1'b0;
    end
    flagsM[z8Pkg::flagZ] = res == 8'h00;
    flagsM[z8Pkg::flagS] = res[7];
endtask

task automatic oneOpResult(input logic [3:0] op, input logic [7:0] a, output logic [7:0] res);
    logic cin;
    cin = flagsM[z8Pkg::flagC];
    res = a;
    case (op)
        4'h0: res = a - 8'd1;
        4'h2: res = a + 8'd1;
        4'h1: res = {a[6:0], cin};
        4'h9: res = {a[6:0], a[7]};
        4'hC: res = {cin, a[7:1]};
        4'hD: res = {a[7], a[7:1]};
        4'hE: res = {a[0], a[7:1]};
        4'h6: res = ~a;
        4'hB: res = 8'h00;
        default: res = {a[3:0], a[7:4]};
    endcase
    if (op == 4'h0 || op == 4'h2) begin
        // Signed overflow only at the 7F/80 boundary
        flagsM[z8Pkg::flagV] = (op == 4'h0) ? (a == 8'h80) : (a == 8'h7F);
    end
    if (op == 4'h6) begin
        flagsM[z8Pkg::flagV] = 1'b0;
    end
    if (op inside {4'h1, 4'h9}) begin
        flagsM[z8Pkg::flagC] = a[7];
    end
    if (op inside {4'hC, 4'hD, 4'hE}) begin
        flagsM[z8Pkg::flagC] = a[0];
    end
    if (op != 4'hB) begin
        flagsM[z8Pkg::flagZ] = res == 8'h00;
        flagsM[z8Pkg::flagS] = res[7];
    end
endtask

task automatic setRp(input logic [7:0] v);
    emit(8'h31);
    emit(v);
    modelWrite(z8Pkg::regRpAddr, v);
endtask

task automatic loadImm(input logic [3:0] r, input logic [7:0] v);
    emit({r, 4'hC});
    emit(v);
    modelWrite({rpM, r}, v);
endtask

task automatic loadReg(input logic [3:0] r, input logic [7:0] src);
    emit({r, 4'h8});
    emit(src);
    modelWrite({rpM, r}, modelRead(workAddr(src)));
endtask

task automatic aluRegReg(input logic [3:0] op, input logic [3:0] dst, input logic [3:0] src);
    logic [7:0] res;
    emit({op, 4'h2});
    emit({dst, src});
    twoOpResult(op, modelRead({rpM, dst}), modelRead({rpM, src}), res);
    if (!(op inside {4'h6, 4'h7, 4'hA})) begin
        modelWrite({rpM, dst}, res);
    end
endtask

task automatic aluRegImm(input logic [3:0] op, input logic [7:0] dst, input logic [7:0] imm);
    logic [7:0] addr;
    logic [7:0] res;
    addr = workAddr(dst);
    emit({op, 4'h6});
    emit(dst);
    emit(imm);
    twoOpResult(op, modelRead(addr), imm, res);
    if (!(op inside {4'h6, 4'h7, 4'hA})) begin
        modelWrite(addr, res);
    end
endtask

task automatic aluSingle(input logic [3:0] op, input logic [7:0] operand);
    logic [7:0] addr;
    logic [7:0] res;
    addr = workAddr(operand);
    emit({op, 4'h0});
    emit(operand);
    oneOpResult(op, modelRead(addr), res);
    modelWrite(addr, res);
endtask

task automatic flagOp(input logic [3:0] hi);
    emit({hi, 4'hF});
    if (hi == z8Pkg::miscCcf) begin
        flagsM[z8Pkg::flagC] = !flagsM[z8Pkg::flagC];
    end else begin
        flagsM[z8Pkg::flagC] = (hi == z8Pkg::miscScf);
    end
endtask

// Each path leaves its own marker write
task automatic branchPair(input logic [3:0] cc, input logic useJp);
    logic [7:0] start;
    logic taken;
    start = 8'(progLen);
    taken = condHolds(cc, flagsM);
    if (useJp) begin
        emit({cc, 4'hD});
        emit(8'h00);
        emit(start + 8'd7);
    end else begin
        emit({cc, 4'hB});
        emit(8'h04);
    end
    emit(8'h1C);
    emit(8'h11);
    emit(8'h8B);
    emit(8'h02);
    emit(8'h2C);
    emit(8'h22);
    if (taken) begin
        modelWrite({rpM, 4'h2}, 8'h22);
    end else begin
        modelWrite({rpM, 4'h1}, 8'h11);
    end
endtask

task automatic testLoads();
    beginProgram("loads and srp");
    setRp(8'h20);
    loadImm(4'h3, 8'h5C);
    loadImm(4'h4, 8'h81);
    loadReg(4'h5, 8'hE3);
    loadReg(4'h6, 8'h24);
    setRp(8'h40);
    loadReg(4'h0, 8'h23);
    loadReg(4'h1, z8Pkg::regRpAddr);
    runProgram();
endtask

task automatic testAluTwoOp();
    logic [3:0] ops [10];
    logic [7:0] aVals [10];
    logic [7:0] bVals [10];
    int k;
    ops = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hA, 4'hB};
    aVals = '{8'h7F, 8'h3C, 8'h10, 8'h80, 8'hA5, 8'hF0, 8'h0F, 8'hC3, 8'h55, 8'h99};
    bVals = '{8'h01, 8'hC8, 8'h21, 8'h01, 8'h5A, 8'h3C, 8'h3F, 8'h41, 8'h55, 8'h99};
    beginProgram("two-operand ALU");
    setRp(8'h10);
    for (k = 0; k < 10; k++) begin
        loadImm(4'h1, aVals[k]);
        loadImm(4'h2, bVals[k]);
        aluRegReg(ops[k], 4'h1, 4'h2);
        loadReg(4'hE, z8Pkg::regFlagsAddr);
        loadImm(4'h1, bVals[k]);
        aluRegImm(ops[k], 8'hE1, aVals[k] ^ 8'h0F);
        loadReg(4'hE, z8Pkg::regFlagsAddr);
    end
    runProgram();
endtask

task automatic testAluOneOp();
    logic [3:0] ops [10];
    logic [7:0] vals [10];
    int k;
    ops = '{4'h0, 4'h1, 4'h2, 4'h6, 4'h9, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
    vals = '{8'h80, 8'h81, 8'h7F, 8'h5A, 8'hC1, 8'h66, 8'h03, 8'h82, 8'h01, 8'h3E};
    beginProgram("single-operand ALU");
    setRp(8'h30);
    for (k = 0; k < 10; k++) begin
        loadImm(4'h4, vals[k]);
        // Alternate carry in for the rotates
        flagOp(k[0] ? z8Pkg::miscScf : z8Pkg::miscRcf);
        aluSingle(ops[k], k[0] ? 8'hE4 : 8'h34);
        loadReg(4'hE, z8Pkg::regFlagsAddr);
    end
    runProgram();
endtask

task automatic testBranches();
    logic [7:0] fv [8];
    int k;
    fv = '{8'h00, 8'h80, 8'h40, 8'h20, 8'h10, 8'h30, 8'hA0, 8'h50};
    beginProgram("branches");
    for (k = 0; k < 8; k++) begin
        aluRegImm(4'h5, z8Pkg::regFlagsAddr, 8'h00);
        aluRegImm(4'h4, z8Pkg::regFlagsAddr, fv[k]);
        branchPair(4'(k), 1'b0);
        branchPair(4'(k + 8), 1'b1);
    end
    runProgram();
endtask

task automatic testFlagOps();
    beginProgram("flag instructions");
    flagOp(z8Pkg::miscScf);
    emit(8'hFF);
    loadReg(4'hE, z8Pkg::regFlagsAddr);
    flagOp(z8Pkg::miscCcf);
    emit(8'hFF);
    loadReg(4'hE, z8Pkg::regFlagsAddr);
    flagOp(z8Pkg::miscCcf);
    flagOp(z8Pkg::miscRcf);
    emit(8'hFF);
    loadReg(4'hE, z8Pkg::regFlagsAddr);
    // Direct write to FC shows on the flags port
    aluRegImm(4'h4, z8Pkg::regFlagsAddr, 8'h43);
    emit(8'hFF);
    runProgram();
endtask

// File: dv/z8Tb.sv
module z8Tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic arstN;
    logic memReqValid;
    logic memReqReady;
    logic [7:0] memAddr;
    logic [7:0] memRspData;
    logic wbValid;
    logic [7:0] wbAddr;
    logic [7:0] wbData;
    logic [7:0] flags;

    logic [7:0] code [256];
    logic rspPending;
    logic [7:0] rspAddr;
    logic stallMode;
    int seed;
    logic [7:0] gotAddr [$];
    logic [7:0] gotData [$];
    logic [7:0] expAddr [$];
    logic [7:0] expData [$];
    logic progDone;
    int progLen;
    int cycleCount;
    int cycleLimit;
    int errorCount;
    int checkCount;

    // Reference state of the core
    logic [7:0] regM [128];
    logic [7:0] flagsM;
    logic [3:0] rpM;

    z8Core z8Core_inst (
        .clk(clk),
        .arstN(arstN),
        .memReqValid(memReqValid),
        .memReqReady(memReqReady),
        .memAddr(memAddr),
        .memRspData(memRspData),
        .wbValid(wbValid),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .flags(flags)
    );

    always #5 clk = ~clk;

    // Code memory answers one cycle after the accepting edge
    always @(negedge clk) begin
        memRspData = rspPending ? code[rspAddr] : 8'h00;
        memReqReady = stallMode ? 1'($random(seed)) : 1'b1;
        rspPending = arstN && memReqValid && memReqReady;
        rspAddr = memAddr;
    end

    always @(negedge clk) begin
        if (arstN && wbValid) begin
            gotAddr.push_back(wbAddr);
            gotData.push_back(wbData);
            // End marker of every program
            if (wbAddr[3:0] == 4'hF && wbData == 8'hA5) begin
                progDone = 1'b1;
            end
        end
    end

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic printSummary();
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
    endtask

    function automatic logic [7:0] workAddr(input logic [7:0] operand);
        return (operand[7:4] == 4'hE) ? {rpM, operand[3:0]} : operand;
    endfunction

    function automatic logic [7:0] modelRead(input logic [7:0] addr);
        if (addr == z8Pkg::regFlagsAddr) begin
            return flagsM;
        end
        if (addr == z8Pkg::regRpAddr) begin
            return {rpM, 4'h0};
        end
        return addr[7] ? 8'h00 : regM[addr[6:0]];
    endfunction

    task automatic modelWrite(input logic [7:0] addr, input logic [7:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
        if (addr == z8Pkg::regFlagsAddr) begin
            flagsM = data;
        end else if (addr == z8Pkg::regRpAddr) begin
            rpM = data[7:4];
        end else if (!addr[7]) begin
            regM[addr[6:0]] = data;
        end
    endtask

    task automatic emit(input logic [7:0] b);
        code[progLen] = b;
        progLen++;
    endtask

    task automatic beginProgram(input string title);
        int i;
        @(negedge clk);
        arstN = 1'b0;
        $display("Running %s, stall mode %0d", title, stallMode);
        for (i = 0; i < 256; i++) begin
            code[i] = {i[7:4] ^ i[3:0], 4'hE};
        end
        for (i = 0; i < 128; i++) begin
            regM[i] = 8'h00;
        end
        expAddr.delete();
        expData.delete();
        gotAddr.delete();
        gotData.delete();
        progLen = 0;
        progDone = 1'b0;
        flagsM = 8'h00;
        rpM = 4'h0;
    endtask

    task automatic runProgram();
        int i;
        loadImm(4'hF, 8'hA5);
        // Park the core on a jump to itself
        emit(8'h8B);
        emit(8'hFE);
        cycleLimit = 400 * progLen;
        cycleCount = 0;
        repeat (2) @(negedge clk);
        // Reset state of the core
        checkEq("memReqValid in reset", memReqValid, 1'b0);
        checkEq("wbValid in reset", wbValid, 1'b0);
        checkEq("memAddr in reset", memAddr, 8'h00);
        checkEq("flags in reset", flags, 8'h00);
        arstN = 1'b1;
        while (!progDone) begin
            @(negedge clk);
        end
        checkEq("write count", gotAddr.size(), expAddr.size());
        for (i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
            checkEq($sformatf("wbAddr #%0d", i), gotAddr[i], expAddr[i]);
            checkEq($sformatf("wbData #%0d", i), gotData[i], expData[i]);
        end
        checkEq("flags", flags, flagsM);
    endtask

    `include "z8TbTasks.svh"

    initial begin
        cycleCount = 0;
        @(posedge clk);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        errorCount++;
        $display("Timeout: the program did not reach its end marker within %0d cycles",
            cycleLimit);
        printSummary();
        $finish;
    end

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        memReqReady = 1'b0;
        memRspData = 8'h00;
        rspPending = 1'b0;
        rspAddr = 8'h00;
        stallMode = 1'b0;
        seed = 92420;
        errorCount = 0;
        checkCount = 0;
        cycleLimit = 1000;
        progDone = 1'b0;
        testLoads();
        testAluTwoOp();
        testAluOneOp();
        testBranches();
        testFlagOps();
        // Same programs with a randomly stalling memory
        stallMode = 1'b1;
        testLoads();
        testAluTwoOp();
        testAluOneOp();
        printSummary();
        $finish;
    end
endmodule

// File: logic/z8Core.sv
module z8Core (
    input  logic clk,
    input  logic arstN,
    output logic memReqValid,
    input  logic memReqReady,
    output logic [z8Pkg::byteW-1:0] memAddr,
    input  logic [z8Pkg::byteW-1:0] memRspData,
    output logic wbValid,
    output logic [z8Pkg::byteW-1:0] wbAddr,
    output logic [z8Pkg::byteW-1:0] wbData,
    output logic [z8Pkg::byteW-1:0] flags
);
    logic [4:0] aluMode;
    logic [z8Pkg::byteW-1:0] aluA;
    logic [z8Pkg::byteW-1:0] aluB;
    logic [z8Pkg::byteW-1:0] aluFlagsIn;
    logic [z8Pkg::byteW-1:0] aluOut;
    logic [z8Pkg::byteW-1:0] aluFlagsOut;

    instrIf instr ();
    regIf regs ();

    fetchUnit fetchUnit_inst (
        .clk(clk),
        .arstN(arstN),
        .memReqValid(memReqValid),
        .memReqReady(memReqReady),
        .memAddr(memAddr),
        .memRspData(memRspData),
        .instr(instr.fetch)
    );

    execUnit execUnit_inst (
        .clk(clk),
        .arstN(arstN),
        .instr(instr.exec),
        .regs(regs.exec),
        .aluMode(aluMode),
        .aluA(aluA),
        .aluB(aluB),
        .aluFlagsIn(aluFlagsIn),
        .aluOut(aluOut),
        .aluFlagsOut(aluFlagsOut)
    );

    aluUnit aluUnit_inst (
        .aluMode(aluMode),
        .aluA(aluA),
        .aluB(aluB),
        .aluFlagsIn(aluFlagsIn),
        .aluOut(aluOut),
        .aluFlagsOut(aluFlagsOut)
    );

    regFile regFile_inst (
        .clk(clk),
        .arstN(arstN),
        .regs(regs.rf),
        .flags(flags)
    );

    // Write trace
    assign wbValid = regs.wrEn;
    assign wbAddr = regs.wrAddr;
    assign wbData = regs.wrData;
endmodule

// File: logic/execUnit.sv
module execUnit (
    input  logic clk,
    input  logic arstN,
    instrIf.exec instr,
    regIf.exec regs,
    output logic [4:0] aluMode,
    output logic [z8Pkg::byteW-1:0] aluA,
    output logic [z8Pkg::byteW-1:0] aluB,
    output logic [z8Pkg::byteW-1:0] aluFlagsIn,
    input  logic [z8Pkg::byteW-1:0] aluOut,
    input  logic [z8Pkg::byteW-1:0] aluFlagsOut
);
    logic execValid;
    logic [z8Pkg::byteW-1:0] irOp;
    logic [z8Pkg::byteW-1:0] irSecond;
    logic [z8Pkg::byteW-1:0] irThird;
    logic [z8Pkg::byteW-1:0] irNextPc;
    logic [3:0] hi;
    logic [3:0] lo;
    z8Pkg::regOperand_u operand;
    logic [z8Pkg::byteW-1:0] operandAddr;
    logic condBase;
    logic isBranch;
    logic wrEnC;
    logic flagsWrEnC;

    assign hi = irOp[7:4];
    assign lo = irOp[3:0];
    assign operand = irSecond;
    assign operandAddr = (operand.work.escape == z8Pkg::workEscape) ?
        {regs.rp, operand.work.num} : operand.raw;

    // Single-cycle execute, so the latch is always free again
    assign instr.ready = 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            execValid <= 1'b0;
        end else begin
            execValid <= instr.valid && instr.ready && !instr.redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (instr.valid && instr.ready) begin
            irOp <= instr.opcode;
            irSecond <= instr.second;
            irThird <= instr.third;
            irNextPc <= instr.nextPc;
        end
    end

    always_comb begin
        case (hi[2:0])
            3'd0: condBase = 1'b0;
            3'd1: condBase = regs.flags[z8Pkg::flagS] ^ regs.flags[z8Pkg::flagV];
            3'd2: condBase = (regs.flags[z8Pkg::flagS] ^ regs.flags[z8Pkg::flagV]) |
                             regs.flags[z8Pkg::flagZ];
            3'd3: condBase = regs.flags[z8Pkg::flagC] | regs.flags[z8Pkg::flagZ];
            3'd4: condBase = regs.flags[z8Pkg::flagV];
            3'd5: condBase = regs.flags[z8Pkg::flagS];
            3'd6: condBase = regs.flags[z8Pkg::flagZ];
            default: condBase = regs.flags[z8Pkg::flagC];
        endcase
    end

    always_comb begin
        regs.rdAddrA = operandAddr;
        regs.rdAddrB = {regs.rp, irSecond[3:0]};
        regs.wrAddr = operandAddr;
        regs.flagsNew = aluFlagsOut;
        aluMode = z8Pkg::aluLd;
        aluA = regs.rdDataA;
        aluB = regs.rdDataB;
        wrEnC = 1'b0;
        flagsWrEnC = 1'b0;
        isBranch = 1'b0;
        instr.target = irThird;
        case (lo)
            z8Pkg::opAlu1: begin
                if ({1'b0, hi} inside {z8Pkg::alu1Dec, z8Pkg::alu1Rlc, z8Pkg::alu1Inc,
                        z8Pkg::alu1Com, z8Pkg::alu1Rl, z8Pkg::alu1Clr, z8Pkg::alu1Rrc,
                        z8Pkg::alu1Sra, z8Pkg::alu1Rr, z8Pkg::alu1Swap}) begin
                    aluMode = {1'b0, hi};
                    wrEnC = 1'b1;
                    flagsWrEnC = 1'b1;
                end
            end
            z8Pkg::opSrp: begin
                aluA = irSecond;
                regs.wrAddr = z8Pkg::regRpAddr;
                wrEnC = 1'b1;
            end
            z8Pkg::opAluRr, z8Pkg::opAluIm: begin
                if (hi inside {[4'h0:4'h7], 4'hA, 4'hB}) begin
                    aluMode = {1'b1, hi};
                    flagsWrEnC = 1'b1;
                    // Compare and test only set flags
                    wrEnC = !({1'b1, hi} inside {z8Pkg::alu2Tcm, z8Pkg::alu2Tm, z8Pkg::alu2Cp});
                    if (lo == z8Pkg::opAluRr) begin
                        regs.rdAddrA = {regs.rp, irSecond[7:4]};
                        regs.wrAddr = {regs.rp, irSecond[7:4]};
                    end else begin
                        aluB = irThird;
                    end
                end
            end
            z8Pkg::opLdRR: begin
                regs.wrAddr = {regs.rp, hi};
                wrEnC = 1'b1;
            end
            z8Pkg::opLdImm: begin
                aluA = irSecond;
                regs.wrAddr = {regs.rp, hi};
                wrEnC = 1'b1;
            end
            z8Pkg::opJr: begin
                isBranch = 1'b1;
                // 8-bit wrap gives the signed offset
                instr.target = irNextPc + irSecond;
            end
            z8Pkg::opJp: isBranch = 1'b1;
            z8Pkg::opMisc: begin
                if (hi inside {z8Pkg::miscRcf, z8Pkg::miscScf, z8Pkg::miscCcf}) begin
                    flagsWrEnC = 1'b1;
                    regs.flagsNew = regs.flags;
                    regs.flagsNew[z8Pkg::flagC] = (hi == z8Pkg::miscCcf) ?
                        !regs.flags[z8Pkg::flagC] : hi[0];
                end
            end
            default: begin
                // Unsupported opcodes retire as nop
            end
        endcase
    end

    assign regs.wrEn = execValid && wrEnC;
    assign regs.wrData = aluOut;
    assign regs.flagsWrEn = execValid && flagsWrEnC;
    assign instr.redirect = execValid && isBranch && (condBase ^ hi[3]);
    assign aluFlagsIn = regs.flags;

    // Results only come from an instruction handed over one cycle earlier
    assert property (@(posedge clk) disable iff (!arstN)
        (regs.wrEn || instr.redirect) |-> $past(instr.valid && instr.ready));
endmodule

// File: logic/fetchUnit.sv
module fetchUnit (
    input  logic clk,
    input  logic arstN,
    output logic memReqValid,
    input  logic memReqReady,
    output logic [z8Pkg::byteW-1:0] memAddr,
    input  logic [z8Pkg::byteW-1:0] memRspData,
    instrIf.fetch instr
);
    logic [z8Pkg::byteW-1:0] pc;
    logic [1:0] reqIdx;
    logic [1:0] rspIdx;
    logic [1:0] len;
    logic [1:0] curLen;
    logic rspPending;
    logic run;
    logic rspTake;
    logic complete;
    logic reqFire;

    function automatic logic [1:0] instrLen(input logic [z8Pkg::byteW-1:0] op);
        if (op[3:1] == 3'b111) begin
            return 2'd1;
        end
        if (op[3:2] == 2'b01 || op[3:0] == z8Pkg::opJp) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

    assign rspTake = rspPending && !instr.redirect;
    // Length is known from the opcode byte while it arrives
    assign curLen = (rspPending && rspIdx == 2'd0) ? instrLen(memRspData) : len;
    assign complete = rspTake && (rspIdx == curLen - 2'd1);

    // Opcode of the next instruction only once the output slot frees up
    assign memReqValid = run && !instr.redirect &&
        ((reqIdx == 2'd0) ? (!instr.valid || instr.ready) : (reqIdx < curLen));
    assign reqFire = memReqValid && memReqReady;
    assign memAddr = pc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            run <= 1'b0;
            pc <= '0;
            reqIdx <= 2'd0;
            rspIdx <= 2'd0;
            rspPending <= 1'b0;
            len <= 2'd1;
            instr.valid <= 1'b0;
        end else begin
            run <= 1'b1;
            rspPending <= reqFire;
            if (reqFire) begin
                rspIdx <= reqIdx;
            end
            if (instr.redirect) begin
                pc <= instr.target;
                reqIdx <= 2'd0;
                instr.valid <= 1'b0;
            end else begin
                if (reqFire) begin
                    pc <= pc + 1'b1;
                    reqIdx <= reqIdx + 2'd1;
                end
                if (rspTake && rspIdx == 2'd0) begin
                    len <= curLen;
                end
                if (complete) begin
                    reqIdx <= 2'd0;
                    instr.valid <= 1'b1;
                end else if (instr.ready) begin
                    instr.valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rspTake) begin
            case (rspIdx)
                2'd0: instr.opcode <= memRspData;
                2'd1: instr.second <= memRspData;
                default: instr.third <= memRspData;
            endcase
        end
        if (complete) begin
            instr.nextPc <= pc;
        end
    end

    // A stalled request keeps its address
    assert property (@(posedge clk) disable iff (!arstN)
        memReqValid && !memReqReady |=> $stable(memAddr));
endmodule

// File: logic/regFile.sv
module regFile (
    input  logic clk,
    input  logic arstN,
    regIf.rf regs,
    output logic [z8Pkg::byteW-1:0] flags
);
    logic [z8Pkg::byteW-1:0] mem [z8Pkg::regFileDepth];
    logic [z8Pkg::byteW-1:0] flagsQ;
    logic [3:0] rpQ;

    function automatic logic [z8Pkg::byteW-1:0] readReg(input logic [z8Pkg::byteW-1:0] addr);
        if (!addr[7]) begin
            return mem[addr[6:0]];
        end
        case (addr)
            z8Pkg::regFlagsAddr: return flagsQ;
            z8Pkg::regRpAddr: return {rpQ, 4'h0};
            default: return '0;
        endcase
    endfunction

    always_comb begin
        regs.rdDataA = readReg(regs.rdAddrA);
        regs.rdDataB = readReg(regs.rdAddrB);
    end

    always_ff @(posedge clk) begin
        if (regs.wrEn && !regs.wrAddr[7]) begin
            mem[regs.wrAddr[6:0]] <= regs.wrData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flagsQ <= '0;
            rpQ <= 4'h0;
        end else begin
            // Explicit register write to FC beats the ALU flag update
            if (regs.wrEn && regs.wrAddr == z8Pkg::regFlagsAddr) begin
                flagsQ <= regs.wrData;
            end else if (regs.flagsWrEn) begin
                flagsQ <= regs.flagsNew;
            end
            if (regs.wrEn && regs.wrAddr == z8Pkg::regRpAddr) begin
                rpQ <= regs.wrData[7:4];
            end
        end
    end

    assign regs.rp = rpQ;
    assign regs.flags = flagsQ;
    assign flags = flagsQ;
endmodule

// File: logic/aluUnit.sv
module aluUnit (
    input  logic [4:0] aluMode,
    input  logic [z8Pkg::byteW-1:0] aluA,
    input  logic [z8Pkg::byteW-1:0] aluB,
    input  logic [z8Pkg::byteW-1:0] aluFlagsIn,
    output logic [z8Pkg::byteW-1:0] aluOut,
    output logic [z8Pkg::byteW-1:0] aluFlagsOut
);
    logic carryIn;
    logic [4:0] lowSum;
    logic [4:0] highSum;
    logic [z8Pkg::byteW-1:0] andA;

    // Carry in only for adc and sbc
    assign carryIn = aluFlagsIn[z8Pkg::flagC] & aluMode[0];
    // tcm works on the complement
    assign andA = aluMode[0] ? aluA : ~aluA;

    always_comb begin
        aluOut = aluA;
        aluFlagsOut = aluFlagsIn;
        lowSum = '0;
        highSum = '0;
        case (aluMode)
            z8Pkg::alu1Dec, z8Pkg::alu1Inc: begin
                aluOut = aluMode[1] ? aluA + 1'b1 : aluA - 1'b1;
                // Overflow only when the sign flips away from the operand's sign
                aluFlagsOut[z8Pkg::flagV] = aluMode[1] ? (!aluA[7] && aluOut[7]) :
                    (aluA[7] && !aluOut[7]);
            end
            z8Pkg::alu1Rlc: begin
                aluOut = {aluA[6:0], aluFlagsIn[z8Pkg::flagC]};
                aluFlagsOut[z8Pkg::flagC] = aluA[7];
            end
            z8Pkg::alu1Rl: begin
                aluOut = {aluA[6:0], aluA[7]};
                aluFlagsOut[z8Pkg::flagC] = aluA[7];
            end
            z8Pkg::alu1Rrc: begin
                aluOut = {aluFlagsIn[z8Pkg::flagC], aluA[7:1]};
                aluFlagsOut[z8Pkg::flagC] = aluA[0];
            end
            z8Pkg::alu1Sra, z8Pkg::alu1Rr: begin
                aluOut = {(aluMode == z8Pkg::alu1Sra) ? aluA[7] : aluA[0], aluA[7:1]};
                aluFlagsOut[z8Pkg::flagC] = aluA[0];
            end
            z8Pkg::alu1Com: begin
                aluOut = ~aluA;
                aluFlagsOut[z8Pkg::flagV] = 1'b0;
            end
            z8Pkg::alu1Clr: aluOut = '0;
            z8Pkg::alu1Swap: aluOut = {aluA[3:0], aluA[7:4]};
            z8Pkg::alu2Add, z8Pkg::alu2Adc: begin
                lowSum = {1'b0, aluA[3:0]} + {1'b0, aluB[3:0]} + {4'b0, carryIn};
                highSum = {1'b0, aluA[7:4]} + {1'b0, aluB[7:4]} + {4'b0, lowSum[4]};
                aluOut = {highSum[3:0], lowSum[3:0]};
                aluFlagsOut[z8Pkg::flagD] = 1'b0;
            end
            z8Pkg::alu2Sub, z8Pkg::alu2Sbc, z8Pkg::alu2Cp: begin
                // Bit 4 is the borrow out of each nibble
                lowSum = {1'b0, aluA[3:0]} - {1'b0, aluB[3:0]} - {4'b0, carryIn};
                highSum = {1'b0, aluA[7:4]} - {1'b0, aluB[7:4]} - {4'b0, lowSum[4]};
                aluOut = {highSum[3:0], lowSum[3:0]};
                aluFlagsOut[z8Pkg::flagD] = 1'b1;
            end
            z8Pkg::alu2Or: aluOut = aluA | aluB;
            z8Pkg::alu2And, z8Pkg::alu2Tcm, z8Pkg::alu2Tm: aluOut = andA & aluB;
            z8Pkg::alu2Xor: aluOut = aluA ^ aluB;
            default: aluOut = aluA;
        endcase

        if (aluMode inside {[z8Pkg::alu2Add:z8Pkg::alu2Sbc], z8Pkg::alu2Cp}) begin
            aluFlagsOut[z8Pkg::flagH] = lowSum[4];
            aluFlagsOut[z8Pkg::flagC] = highSum[4];
            aluFlagsOut[z8Pkg::flagV] = (aluA[7] == aluB[7]) && (aluA[7] != aluOut[7]);
        end else if (aluMode inside {[z8Pkg::alu2Or:z8Pkg::alu2Tm], z8Pkg::alu2Xor}) begin
            aluFlagsOut[z8Pkg::flagV] = 1'b0;
        end

        if (aluMode != z8Pkg::alu1Clr && aluMode != z8Pkg::aluLd) begin
            aluFlagsOut[z8Pkg::flagZ] = aluOut == '0;
            aluFlagsOut[z8Pkg::flagS] = aluOut[7];
        end
    end

    // Decode never selects an unsupported operation
    modeKnown: assert final (aluMode inside {
        z8Pkg::alu1Dec, z8Pkg::alu1Rlc, z8Pkg::alu1Inc, z8Pkg::aluLd, z8Pkg::alu1Com,
        z8Pkg::alu1Rl, z8Pkg::alu1Clr, z8Pkg::alu1Rrc, z8Pkg::alu1Sra, z8Pkg::alu1Rr,
        z8Pkg::alu1Swap, [z8Pkg::alu2Add:z8Pkg::alu2Tm], z8Pkg::alu2Cp, z8Pkg::alu2Xor});
endmodule

// File: logic/z8Ifs.sv
interface instrIf;
    logic valid;
    logic ready;
    logic [z8Pkg::byteW-1:0] opcode;
    logic [z8Pkg::byteW-1:0] second;
    logic [z8Pkg::byteW-1:0] third;
    logic [z8Pkg::byteW-1:0] nextPc;
    logic redirect;
    logic [z8Pkg::byteW-1:0] target;

    modport fetch (
        output valid, opcode, second, third, nextPc,
        input ready, redirect, target
    );
    modport exec (
        input valid, opcode, second, third, nextPc,
        output ready, redirect, target
    );
endinterface

interface regIf;
    logic [z8Pkg::byteW-1:0] rdAddrA;
    logic [z8Pkg::byteW-1:0] rdAddrB;
    logic [z8Pkg::byteW-1:0] rdDataA;
    logic [z8Pkg::byteW-1:0] rdDataB;
    logic wrEn;
    logic [z8Pkg::byteW-1:0] wrAddr;
    logic [z8Pkg::byteW-1:0] wrData;
    logic flagsWrEn;
    logic [z8Pkg::byteW-1:0] flagsNew;
    logic [3:0] rp;
    logic [z8Pkg::byteW-1:0] flags;

    modport exec (
        output rdAddrA, rdAddrB, wrEn, wrAddr, wrData, flagsWrEn, flagsNew,
        input rdDataA, rdDataB, rp, flags
    );
    modport rf (
        input rdAddrA, rdAddrB, wrEn, wrAddr, wrData, flagsWrEn, flagsNew,
        output rdDataA, rdDataB, rp, flags
    );
endinterface

// File: logic/z8Pkg.sv
package z8Pkg;

    localparam int byteW = 8;
    localparam int regFileDepth = 128;

    // Instruction class from the low opcode nibble
    localparam logic [3:0] opAlu1 = 4'h0;
    localparam logic [3:0] opSrp = 4'h1;
    localparam logic [3:0] opAluRr = 4'h2;
    localparam logic [3:0] opAluIm = 4'h6;
    localparam logic [3:0] opLdRR = 4'h8;
    localparam logic [3:0] opJr = 4'hB;
    localparam logic [3:0] opLdImm = 4'hC;
    localparam logic [3:0] opJp = 4'hD;
    localparam logic [3:0] opMisc = 4'hF;

    localparam logic [3:0] miscRcf = 4'hC;
    localparam logic [3:0] miscScf = 4'hD;
    localparam logic [3:0] miscCcf = 4'hE;

    // Single-operand modes take the opcode high nibble
    localparam logic [4:0] alu1Dec = 5'h00;
    localparam logic [4:0] alu1Rlc = 5'h01;
    localparam logic [4:0] alu1Inc = 5'h02;
    localparam logic [4:0] aluLd = 5'h05;
    localparam logic [4:0] alu1Com = 5'h06;
    localparam logic [4:0] alu1Rl = 5'h09;
    localparam logic [4:0] alu1Clr = 5'h0B;
    localparam logic [4:0] alu1Rrc = 5'h0C;
    localparam logic [4:0] alu1Sra = 5'h0D;
    localparam logic [4:0] alu1Rr = 5'h0E;
    localparam logic [4:0] alu1Swap = 5'h0F;
    localparam logic [4:0] alu2Add = 5'h10;
    localparam logic [4:0] alu2Adc = 5'h11;
    localparam logic [4:0] alu2Sub = 5'h12;
    localparam logic [4:0] alu2Sbc = 5'h13;
    localparam logic [4:0] alu2Or = 5'h14;
    localparam logic [4:0] alu2And = 5'h15;
    localparam logic [4:0] alu2Tcm = 5'h16;
    localparam logic [4:0] alu2Tm = 5'h17;
    localparam logic [4:0] alu2Cp = 5'h1A;
    localparam logic [4:0] alu2Xor = 5'h1B;

    localparam int flagC = 7;
    localparam int flagZ = 6;
    localparam int flagS = 5;
    localparam int flagV = 4;
    localparam int flagD = 3;
    localparam int flagH = 2;

    localparam logic [byteW-1:0] regFlagsAddr = 8'hFC;
    localparam logic [byteW-1:0] regRpAddr = 8'hFD;
    localparam logic [3:0] workEscape = 4'hE;

    // Operand byte, either a full address or a working register
    typedef union packed {
        logic [byteW-1:0] raw;
        struct packed {
            logic [3:0] escape;
            logic [3:0] num;
        } work;
    } regOperand_u;

endpackage
